// ==== Bender.yml ====
package:
  name: jtag_dtm

sources:
  - logic/dtm_pkg.sv
  - logic/jtag_tap.sv
  - logic/dtm_dr_shift.sv
  - logic/dtm_ctrl_regs.sv
  - logic/dmi_wb_master.sv
  - logic/dm_reg_bank.sv
  - logic/dtm_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_dtm_top.sv

// ==== compile.f ====
+incdir+include
logic/dtm_pkg.sv
logic/jtag_tap.sv
logic/dtm_dr_shift.sv
logic/dtm_ctrl_regs.sv
logic/dmi_wb_master.sv
logic/dm_reg_bank.sv
logic/dtm_top.sv
verif/tb_dtm_top.sv

// ==== logic/dm_reg_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module dm_reg_bank (
  input  logic             tck,
  input  logic             trst_ni,
  input  dtm_pkg::wb_req_t wb_req_i,
  output dtm_pkg::wb_rsp_t wb_rsp_o
);

  logic [31:0]                       regs_q [dtm_pkg::DM_NUM_REGS];
  logic [dtm_pkg::DM_WAIT_WIDTH-1:0] wait_q;  // Cycles since stb was seen
  logic                              ack_q;
  logic                              err_q;
  logic [31:0]                       rdata_q;
  logic [dtm_pkg::DM_IDX_WIDTH-1:0]  idx;
  logic                              mapped;
  logic                              done;

  assign idx    = wb_req_i.adr[dtm_pkg::DM_IDX_WIDTH-1:0];
  assign mapped = (wb_req_i.adr < dtm_pkg::DM_NUM_REGS);

  // Last wait state, response registered on this edge
  assign done = wb_req_i.cyc && wb_req_i.stb && !ack_q && !err_q &&
                (wait_q == dtm_pkg::DM_WAIT_CYCLES - 1);

  always_ff @(posedge tck or negedge trst_ni) begin
    if (!trst_ni) begin
      wait_q <= '0;
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
      for (int i = 0; i < dtm_pkg::DM_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      ack_q <= done && mapped;
      err_q <= done && !mapped;       // Unmapped address
      if (!(wb_req_i.cyc && wb_req_i.stb) || ack_q || err_q || done) begin
        wait_q <= '0;
      end else begin
        wait_q <= wait_q + 1'b1;
      end
      if (done && mapped && wb_req_i.we) begin
        regs_q[idx] <= wb_req_i.dat;
      end
    end
  end

  // Read data launched with ack
  always_ff @(posedge tck) begin
    if (done) begin
      rdata_q <= mapped ? regs_q[idx] : '0;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.err = err_q;
  assign wb_rsp_o.dat = rdata_q;

  // One response of one cycle per access
  a_single_rsp: assert property (@(posedge tck) disable iff (!trst_ni)
    (wb_rsp_o.ack || wb_rsp_o.err) |->
      !(wb_rsp_o.ack && wb_rsp_o.err) ##1 !(wb_rsp_o.ack || wb_rsp_o.err))
    else $error("Wishbone ack and err overlap or last too long");

endmodule

`default_nettype wire

// ==== logic/dmi_wb_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmi_wb_master (
  input  logic                 tck,
  input  logic                 trst_ni,
  input  dtm_pkg::tap_ctrl_t   tap_ctrl_i,
  input  logic                 dmi_clear_i,
  input  logic                 dmi_status_clear_i,
  output dtm_pkg::dmi_status_e dmi_status_o,
  output logic                 dmi_tdo_o,
  output dtm_pkg::wb_req_t     wb_req_o,
  input  dtm_pkg::wb_rsp_t     wb_rsp_i
);

  typedef enum logic [2:0] { Idle, Read, WaitRead, Write, WaitWrite } state_e;

  state_e                        state_q, state_d;
  logic [dtm_pkg::DMI_ABITS-1:0] addr_q, addr_d;
  logic [31:0]                   data_q, data_d;
  dtm_pkg::dmi_status_e          status_q, status_d;
  dtm_pkg::dmi_dr_t              dr_q;
  dtm_pkg::dmi_dr_t              dr_capture;
  logic                          dmi_update;
  logic                          dmi_capture;
  logic                          rsp_valid;
  logic                          busy_now;
  logic                          op_failed;

  assign dmi_update  = tap_ctrl_i.update && tap_ctrl_i.dmi_sel;
  assign dmi_capture = tap_ctrl_i.capture && tap_ctrl_i.dmi_sel;
  assign rsp_valid   = wb_rsp_i.ack || wb_rsp_i.err;

  // Scan overtook the access in flight
  assign busy_now = (dmi_update && state_q != Idle) ||
                    (dmi_capture && state_q inside {Read, WaitRead});

  // ----------------------------------------
  // Access FSM and sticky status
  // ----------------------------------------
  always_comb begin
    state_d   = state_q;
    addr_d    = addr_q;
    data_d    = data_q;
    status_d  = status_q;
    op_failed = 1'b0;

    case (state_q)
      Idle: begin
        if (dmi_update && status_q == dtm_pkg::DMI_NO_ERROR) begin
          addr_d = dr_q.address;
          data_d = dr_q.data;
          case (dtm_pkg::dtm_op_e'(dr_q.op))
            dtm_pkg::DTM_READ:  state_d = Read;
            dtm_pkg::DTM_WRITE: state_d = Write;
            default: ;                          // Nop or reserved
          endcase
        end
      end
      Read, WaitRead: begin
        if (rsp_valid) begin
          data_d    = wb_rsp_i.err ? 32'hDEAD_BEEF : wb_rsp_i.dat;
          op_failed = wb_rsp_i.err;
          state_d   = Idle;
        end else begin
          state_d = WaitRead;
        end
      end
      Write, WaitWrite: begin
        if (rsp_valid) begin
          op_failed = wb_rsp_i.err;
          state_d   = Idle;
        end else begin
          state_d = WaitWrite;
        end
      end
      default: state_d = Idle;
    endcase

    // First error wins until cleared
    if (status_q == dtm_pkg::DMI_NO_ERROR) begin
      if (op_failed) begin
        status_d = dtm_pkg::DMI_OP_FAILED;
      end else if (busy_now) begin
        status_d = dtm_pkg::DMI_BUSY;
      end
    end

    if (dmi_status_clear_i) status_d = dtm_pkg::DMI_NO_ERROR;

    if (dmi_clear_i) begin
      state_d  = Idle;
      addr_d   = '0;
      data_d   = '0;
      status_d = dtm_pkg::DMI_NO_ERROR;
    end
  end

  always_ff @(posedge tck or negedge trst_ni) begin
    if (!trst_ni) begin
      state_q  <= Idle;
      addr_q   <= '0;
      data_q   <= '0;
      status_q <= dtm_pkg::DMI_NO_ERROR;
    end else begin
      state_q  <= state_d;
      addr_q   <= addr_d;
      data_q   <= data_d;
      status_q <= status_d;
    end
  end

  // ----------------------------------------
  // DMI data register
  // ----------------------------------------
  assign dr_capture.address = addr_q;
  assign dr_capture.data    = data_q;
  assign dr_capture.op      = busy_now ? dtm_pkg::DMI_BUSY : status_q;

  dtm_dr_shift #(
    .payload_t (dtm_pkg::dmi_dr_t)
  ) u_dmi_dr (
    .tck           (tck),
    .trst_ni       (trst_ni),
    .clear_i       (dmi_clear_i),
    .capture_i     (dmi_capture),
    .shift_i       (tap_ctrl_i.shift && tap_ctrl_i.dmi_sel),
    .tdi_i         (tap_ctrl_i.tdi),
    .capture_val_i (dr_capture),
    .data_o        (dr_q)
  );

  assign dmi_tdo_o    = dr_q[0];
  assign dmi_status_o = status_q;

  // Wishbone request held from state until ack or err
  assign wb_req_o.cyc = (state_q != Idle);
  assign wb_req_o.stb = (state_q != Idle);
  assign wb_req_o.we  = state_q inside {Write, WaitWrite};
  assign wb_req_o.adr = addr_q;
  assign wb_req_o.dat = data_q;

  a_stb_in_cyc: assert property (@(posedge tck) disable iff (!trst_ni)
    wb_req_o.stb |-> wb_req_o.cyc)
    else $error("Wishbone stb without cyc");

  a_req_stable: assert property (@(posedge tck) disable iff (!trst_ni)
    wb_req_o.stb && !rsp_valid && !dmi_clear_i |=> $stable(wb_req_o))
    else $error("Wishbone request changed before ack or err");

endmodule

`default_nettype wire

// ==== logic/dtm_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtm_ctrl_regs (
  input  logic                 tck,
  input  logic                 trst_ni,
  input  dtm_pkg::tap_ctrl_t   tap_ctrl_i,
  input  dtm_pkg::dmi_status_e dmi_status_i,
  output logic                 dtmcs_tdo_o,
  output logic                 dmi_clear_o,
  output logic                 dmi_status_clear_o
);

  dtm_pkg::dtmcs_t capture_word;
  dtm_pkg::dtmcs_t dtmcs_q;
  logic            dtmcs_update;

  // Read-only view presented at Capture-DR
  assign capture_word = '{
    zero1:        '0,
    dmihardreset: 1'b0,
    dmireset:     1'b0,
    zero0:        1'b0,
    idle:         3'd1,              // Leave Run-Test/Idle at once
    dmistat:      dmi_status_i,
    abits:        6'(dtm_pkg::DMI_ABITS),
    version:      4'd1               // Debug spec 0.13
  };

  dtm_dr_shift #(
    .payload_t (dtm_pkg::dtmcs_t)
  ) u_dtmcs_dr (
    .tck           (tck),
    .trst_ni       (trst_ni),
    .clear_i       (tap_ctrl_i.tap_clear),
    .capture_i     (tap_ctrl_i.capture && tap_ctrl_i.dtmcs_sel),
    .shift_i       (tap_ctrl_i.shift && tap_ctrl_i.dtmcs_sel),
    .tdi_i         (tap_ctrl_i.tdi),
    .capture_val_i (capture_word),
    .data_o        (dtmcs_q)
  );

  assign dtmcs_tdo_o  = dtmcs_q[0];
  assign dtmcs_update = tap_ctrl_i.update && tap_ctrl_i.dtmcs_sel;

  // Warm reset of the DMI side
  assign dmi_clear_o = tap_ctrl_i.tap_clear || (dtmcs_update && dtmcs_q.dmihardreset);

  assign dmi_status_clear_o = dtmcs_update && dtmcs_q.dmireset; // Sticky status clear

endmodule

`default_nettype wire

// ==== logic/dtm_dr_shift.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtm_dr_shift #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     tck,
  input  logic     trst_ni,
  input  logic     clear_i,
  input  logic     capture_i,
  input  logic     shift_i,
  input  logic     tdi_i,
  input  payload_t capture_val_i,
  output payload_t data_o
);

  localparam int unsigned Width = $bits(payload_t);

  logic [Width-1:0] sr_q;

  always_ff @(posedge tck or negedge trst_ni) begin
    if (!trst_ni) begin
      sr_q <= '0;
    end else if (clear_i) begin
      sr_q <= '0;
    end else if (capture_i) begin
      sr_q <= capture_val_i;               // Parallel load in Capture-DR
    end else if (shift_i) begin
      sr_q <= {tdi_i, sr_q[Width-1:1]};    // TDI in at the MSB, LSB goes to TDO
    end
  end

  assign data_o = payload_t'(sr_q);

endmodule

`default_nettype wire

// ==== logic/dtm_pkg.sv ====
`default_nettype none

package dtm_pkg;

  // ----------------------------------------
  // TAP and instruction register
  // ----------------------------------------
  localparam int unsigned IR_LEN       = 5;
  localparam logic [31:0] IDCODE_VALUE = 32'h1DEB_0001; // LSB must be 1

  localparam logic [IR_LEN-1:0] IR_IDCODE = 5'h01; // Loaded in Test-Logic-Reset
  localparam logic [IR_LEN-1:0] IR_DTMCS  = 5'h10;
  localparam logic [IR_LEN-1:0] IR_DMI    = 5'h11;
  localparam logic [IR_LEN-1:0] IR_BYPASS = 5'h1F;

  // ----------------------------------------
  // DMI and register bank
  // ----------------------------------------
  localparam int unsigned DMI_ABITS      = 7;
  localparam int unsigned DM_NUM_REGS    = 16;
  localparam int unsigned DM_WAIT_CYCLES = 6;  // Wait states before ack or err
  localparam int unsigned DM_IDX_WIDTH   = $clog2(DM_NUM_REGS);
  localparam int unsigned DM_WAIT_WIDTH  = $clog2(DM_WAIT_CYCLES + 1);

  typedef enum logic [1:0] {
    DTM_NOP   = 2'h0,
    DTM_READ  = 2'h1,
    DTM_WRITE = 2'h2,
    DTM_RSVD  = 2'h3
  } dtm_op_e;

  typedef enum logic [1:0] {
    DMI_NO_ERROR  = 2'h0,
    DMI_RESERVED  = 2'h1,
    DMI_OP_FAILED = 2'h2,
    DMI_BUSY      = 2'h3  // Scan arrived before the access finished
  } dmi_status_e;

  typedef struct packed {
    logic [13:0] zero1;
    logic        dmihardreset; // Write 1 to reset the whole DMI
    logic        dmireset;     // Write 1 to clear the sticky status
    logic        zero0;
    logic [2:0]  idle;         // Run-Test/Idle cycles hint
    dmi_status_e dmistat;
    logic [5:0]  abits;
    logic [3:0]  version;
  } dtmcs_t;

  typedef struct packed {
    logic [DMI_ABITS-1:0] address;
    logic [31:0]          data;
    logic [1:0]           op;  // Operation on update, status on capture
  } dmi_dr_t;

  // Strobes broadcast from the TAP
  typedef struct packed {
    logic capture;
    logic shift;
    logic update;
    logic tdi;
    logic dtmcs_sel;
    logic dmi_sel;
    logic tap_clear; // In Test-Logic-Reset
  } tap_ctrl_t;

  // Wishbone classic
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [DMI_ABITS-1:0] adr;
    logic [31:0]          dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

// ==== logic/dtm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtm_top (
  input  logic tck,
  input  logic trst_ni,
  input  logic tms_i,
  input  logic td_i,
  output logic td_o,
  output logic tdo_oe_o
);

  dtm_pkg::tap_ctrl_t   tap_ctrl;
  dtm_pkg::dmi_status_e dmi_status;
  dtm_pkg::wb_req_t     wb_req;
  dtm_pkg::wb_rsp_t     wb_rsp;
  logic                 dtmcs_tdo;
  logic                 dmi_tdo;
  logic                 dmi_clear;
  logic                 dmi_status_clear;

  jtag_tap u_tap (
    .tck         (tck),
    .trst_ni     (trst_ni),
    .tms_i       (tms_i),
    .td_i        (td_i),
    .td_o        (td_o),
    .tdo_oe_o    (tdo_oe_o),
    .tap_ctrl_o  (tap_ctrl),
    .dtmcs_tdo_i (dtmcs_tdo),
    .dmi_tdo_i   (dmi_tdo)
  );

  dtm_ctrl_regs u_dtmcs (
    .tck                (tck),
    .trst_ni            (trst_ni),
    .tap_ctrl_i         (tap_ctrl),
    .dmi_status_i       (dmi_status),
    .dtmcs_tdo_o        (dtmcs_tdo),
    .dmi_clear_o        (dmi_clear),
    .dmi_status_clear_o (dmi_status_clear)
  );

  dmi_wb_master u_dmi (
    .tck                (tck),
    .trst_ni            (trst_ni),
    .tap_ctrl_i         (tap_ctrl),
    .dmi_clear_i        (dmi_clear),
    .dmi_status_clear_i (dmi_status_clear),
    .dmi_status_o       (dmi_status),
    .dmi_tdo_o          (dmi_tdo),
    .wb_req_o           (wb_req),
    .wb_rsp_i           (wb_rsp)
  );

  dm_reg_bank u_dm_regs (
    .tck      (tck),
    .trst_ni  (trst_ni),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

endmodule

`default_nettype wire

// ==== logic/jtag_tap.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_tap (
  input  logic               tck,
  input  logic               trst_ni,
  input  logic               tms_i,
  input  logic               td_i,
  output logic               td_o,
  output logic               tdo_oe_o,
  output dtm_pkg::tap_ctrl_t tap_ctrl_o,
  input  logic               dtmcs_tdo_i,
  input  logic               dmi_tdo_i
);

  typedef enum logic [3:0] {
    TestLogicReset, RunTestIdle, SelectDrScan, CaptureDr,
    ShiftDr, Exit1Dr, PauseDr, Exit2Dr, UpdateDr,
    SelectIrScan, CaptureIr, ShiftIr, Exit1Ir, PauseIr, Exit2Ir, UpdateIr
  } tap_state_e;

  tap_state_e state_q, state_d;

  logic [dtm_pkg::IR_LEN-1:0] ir_shift_q; // IR shift stage
  logic [dtm_pkg::IR_LEN-1:0] ir_q;       // Current instruction
  logic [31:0]                idcode_q;
  logic                       bypass_q;
  logic                       idcode_sel;
  logic                       dr_tdo;

  // ----------------------------------------
  // TAP state machine
  // ----------------------------------------
  always_comb begin
    unique case (state_q)
      TestLogicReset: state_d = tms_i ? TestLogicReset : RunTestIdle;
      RunTestIdle:    state_d = tms_i ? SelectDrScan   : RunTestIdle;
      SelectDrScan:   state_d = tms_i ? SelectIrScan   : CaptureDr;
      CaptureDr:      state_d = tms_i ? Exit1Dr        : ShiftDr;
      ShiftDr:        state_d = tms_i ? Exit1Dr        : ShiftDr;
      Exit1Dr:        state_d = tms_i ? UpdateDr       : PauseDr;
      PauseDr:        state_d = tms_i ? Exit2Dr        : PauseDr;
      Exit2Dr:        state_d = tms_i ? UpdateDr       : ShiftDr;
      UpdateDr:       state_d = tms_i ? SelectDrScan   : RunTestIdle;
      SelectIrScan:   state_d = tms_i ? TestLogicReset : CaptureIr;
      CaptureIr:      state_d = tms_i ? Exit1Ir        : ShiftIr;
      ShiftIr:        state_d = tms_i ? Exit1Ir        : ShiftIr;
      Exit1Ir:        state_d = tms_i ? UpdateIr       : PauseIr;
      PauseIr:        state_d = tms_i ? Exit2Ir        : PauseIr;
      Exit2Ir:        state_d = tms_i ? UpdateIr       : ShiftIr;
      UpdateIr:       state_d = tms_i ? SelectDrScan   : RunTestIdle;
    endcase
  end

  always_ff @(posedge tck or negedge trst_ni) begin
    if (!trst_ni) begin
      state_q <= TestLogicReset;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------
  // IR, IDCODE and BYPASS
  // ----------------------------------------
  assign idcode_sel = (ir_q == dtm_pkg::IR_IDCODE);

  always_ff @(posedge tck or negedge trst_ni) begin
    if (!trst_ni) begin
      ir_shift_q <= '0;
      ir_q       <= dtm_pkg::IR_IDCODE;
      idcode_q   <= dtm_pkg::IDCODE_VALUE;
      bypass_q   <= 1'b0;
    end else begin
      case (state_q)
        TestLogicReset: begin
          ir_q     <= dtm_pkg::IR_IDCODE;
          idcode_q <= dtm_pkg::IDCODE_VALUE;
        end
        CaptureIr: ir_shift_q <= {{(dtm_pkg::IR_LEN-2){1'b0}}, 2'b01}; // Fixed 01 pattern
        ShiftIr:   ir_shift_q <= {td_i, ir_shift_q[dtm_pkg::IR_LEN-1:1]};
        UpdateIr:  ir_q       <= ir_shift_q;
        CaptureDr: begin
          bypass_q <= 1'b0;
          if (idcode_sel) idcode_q <= dtm_pkg::IDCODE_VALUE;
        end
        ShiftDr: begin
          bypass_q <= td_i;
          if (idcode_sel) idcode_q <= {td_i, idcode_q[31:1]};
        end
        default: ;
      endcase
    end
  end

  // DR output by instruction, BYPASS and unknown codes use the bypass bit
  always_comb begin
    case (ir_q)
      dtm_pkg::IR_IDCODE: dr_tdo = idcode_q[0];
      dtm_pkg::IR_DTMCS:  dr_tdo = dtmcs_tdo_i;
      dtm_pkg::IR_DMI:    dr_tdo = dmi_tdo_i;
      default:            dr_tdo = bypass_q;
    endcase
  end

  // TDO launched on the falling edge
  always_ff @(negedge tck or negedge trst_ni) begin
    if (!trst_ni) begin
      td_o     <= 1'b0;
      tdo_oe_o <= 1'b0;
    end else begin
      td_o     <= (state_q == ShiftIr) ? ir_shift_q[0] : dr_tdo;
      tdo_oe_o <= (state_q == ShiftIr) || (state_q == ShiftDr);
    end
  end

  assign tap_ctrl_o.capture   = (state_q == CaptureDr);
  assign tap_ctrl_o.shift     = (state_q == ShiftDr);
  assign tap_ctrl_o.update    = (state_q == UpdateDr);
  assign tap_ctrl_o.tdi       = td_i;
  assign tap_ctrl_o.dtmcs_sel = (ir_q == dtm_pkg::IR_DTMCS);
  assign tap_ctrl_o.dmi_sel   = (ir_q == dtm_pkg::IR_DMI);
  assign tap_ctrl_o.tap_clear = (state_q == TestLogicReset);

  // DR strobes seen by the data registers never overlap
  a_strobes_exclusive: assert property (@(posedge tck) disable iff (!trst_ni)
    $onehot0({tap_ctrl_o.capture, tap_ctrl_o.shift, tap_ctrl_o.update}))
    else $error("TAP capture, shift and update overlap");

endmodule

`default_nettype wire

// ==== include/tb_jtag_tasks.svh ====
`ifndef TB_JTAG_TASKS_SVH
`define TB_JTAG_TASKS_SVH

`default_nettype none

// Pin level JTAG access on tck, tms, tdi and tdo of the including module
// Each task starts and ends 10 ns after a rising tck edge

task automatic jtag_align();
  @(posedge tck);
  #10ns;
endtask

// One TCK cycle, tdo_v is the bit shifted out on this edge
task automatic jtag_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
  tms = tms_v;
  tdi = tdi_v;
  @(posedge tck);
  tdo_v = tdo;
  #10ns;
endtask

task automatic jtag_idle(input int unsigned cycles);
  logic tdo_bit;
  repeat (cycles) jtag_step(1'b0, 1'b0, tdo_bit);
endtask

// Five TMS ones reach Test-Logic-Reset from any state
task automatic jtag_tap_reset();
  logic tdo_bit;
  jtag_align();
  repeat (5) jtag_step(1'b1, 1'b0, tdo_bit);
  jtag_step(1'b0, 1'b0, tdo_bit);                    // Run-Test/Idle
endtask

task automatic jtag_ir_scan(input logic [dtm_pkg::IR_LEN-1:0] ir);
  logic tdo_bit;
  jtag_step(1'b1, 1'b0, tdo_bit);                    // Select-DR-Scan
  jtag_step(1'b1, 1'b0, tdo_bit);                    // Select-IR-Scan
  jtag_step(1'b0, 1'b0, tdo_bit);                    // Capture-IR
  jtag_step(1'b0, 1'b0, tdo_bit);                    // Shift-IR
  for (int i = 0; i < dtm_pkg::IR_LEN; i++) begin
    jtag_step(i == dtm_pkg::IR_LEN - 1, ir[i], tdo_bit); // Last bit exits
  end
  jtag_step(1'b1, 1'b0, tdo_bit);                    // Update-IR
  jtag_step(1'b0, 1'b0, tdo_bit);                    // Run-Test/Idle
endtask

// LSB first, ends in Run-Test/Idle
task automatic jtag_dr_scan(input int unsigned len, input logic [63:0] din,
                            output logic [63:0] dout);
  logic tdo_bit;
  dout = '0;
  jtag_step(1'b1, 1'b0, tdo_bit);                    // Select-DR-Scan
  jtag_step(1'b0, 1'b0, tdo_bit);                    // Capture-DR
  jtag_step(1'b0, 1'b0, tdo_bit);                    // Shift-DR
  for (int i = 0; i < len; i++) begin
    jtag_step(i == len - 1, din[i], tdo_bit);
    dout[i] = tdo_bit;
  end
  jtag_step(1'b1, 1'b0, tdo_bit);                    // Update-DR
  jtag_step(1'b0, 1'b0, tdo_bit);                    // Run-Test/Idle
endtask

`default_nettype wire

`endif

// ==== verif/tb_dtm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dtm_top;

  // Test 3 takes about 40 x 154 tck, the other tests under 2000 together
  localparam int unsigned MAX_CYCLES = 40000;
  localparam int unsigned SETTLE     = dtm_pkg::DM_WAIT_CYCLES + 2; // Idle after an access

  logic tck;
  logic trst_ni;
  logic tms;
  logic tdi;
  logic tdo;
  logic tdo_oe;

  logic [31:0] model [dtm_pkg::DM_NUM_REGS]; // Expected register bank
  logic [1:0]  exp_status;                   // Expected sticky DMI status
  integer      seed;
  int          errors;
  int          tests_failed;
  int unsigned cycles;

  dtm_top dut (
    .tck      (tck),
    .trst_ni  (trst_ni),
    .tms_i    (tms),
    .td_i     (tdi),
    .td_o     (tdo),
    .tdo_oe_o (tdo_oe)
  );

  `include "tb_jtag_tasks.svh"

  always #50ns tck = ~tck;

  // Run limit
  always @(posedge tck) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d tck cycles", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // dtmcs as the spec defines it: idle 1, abits 7, version 1
  function automatic logic [31:0] expected_dtmcs(input logic [1:0] status);
    return {14'h0, 1'b0, 1'b0, 1'b0, 3'd1, status, 6'd7, 4'd1};
  endfunction

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("error: %s got 0x%0h expected 0x%0h", sig, got, exp);
    errors++;
  endtask

  task automatic end_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: FAILED with %0d errors", name, errors - errors_before);
      tests_failed++;
    end
  endtask

  // One DMI scan, then time for the bus access
  task automatic dmi_access(input logic [6:0] addr, input logic [31:0] data,
                            input logic [1:0] op);
    logic [63:0] dout;
    jtag_dr_scan(41, {23'h0, addr, data, op}, dout);
    jtag_idle(SETTLE);
  endtask

  // Nop scan, returns the captured DMI word
  task automatic dmi_result(output logic [6:0] addr, output logic [31:0] data,
                            output logic [1:0] op);
    logic [63:0] dout;
    jtag_dr_scan(41, 64'h0, dout);
    {addr, data, op} = dout[40:0];
  endtask

  task automatic read_and_check(input logic [6:0] addr, input logic [31:0] exp_data,
                                input logic [1:0] exp_op);
    logic [6:0]  r_addr;
    logic [31:0] r_data;
    logic [1:0]  r_op;
    dmi_access(addr, 32'h0, dtm_pkg::DTM_READ);
    dmi_result(r_addr, r_data, r_op);
    if (r_op !== exp_op) report_mismatch("dmi op", r_op, exp_op);
    if (r_data !== exp_data) report_mismatch("dmi data", r_data, exp_data);
    if (r_addr !== addr) report_mismatch("dmi address", r_addr, addr);
  endtask

  // Selects dtmcs, writes wr and returns the captured word
  task automatic dtmcs_scan(input logic [31:0] wr, output logic [31:0] rd);
    logic [63:0] dout;
    jtag_ir_scan(dtm_pkg::IR_DTMCS);
    jtag_dr_scan(32, {32'h0, wr}, dout);
    rd = dout[31:0];
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  initial begin
    logic [63:0] dout;
    logic [31:0] word;
    logic [31:0] rnd;
    logic [6:0]  addr;
    logic [6:0]  r_addr;
    logic [31:0] r_data;
    logic [1:0]  r_op;
    int          err_start;

    tck          = 1'b0;
    trst_ni      = 1'b0;
    tms          = 1'b1;
    tdi          = 1'b0;
    cycles       = 0;
    errors       = 0;
    tests_failed = 0;
    seed         = 32'h5cd4b48b;
    exp_status   = dtm_pkg::DMI_NO_ERROR;
    for (int i = 0; i < dtm_pkg::DM_NUM_REGS; i++) model[i] = 32'h0; // Bank resets to zero
    repeat (2) @(posedge tck);
    #10ns;
    trst_ni = 1'b1;
    jtag_tap_reset();

    // IDCODE after reset, then BYPASS delays by one bit
    err_start = errors;
    if (tdo_oe !== 1'b0) report_mismatch("tdo_oe_o", tdo_oe, 1'b0);
    jtag_dr_scan(32, 64'h0, dout);
    if (dout[31:0] !== dtm_pkg::IDCODE_VALUE) begin
      report_mismatch("td_o idcode", dout[31:0], dtm_pkg::IDCODE_VALUE);
    end
    jtag_ir_scan(dtm_pkg::IR_BYPASS);
    rnd = $random(seed);
    jtag_dr_scan(33, {32'h0, rnd}, dout);
    if (dout[32:0] !== {rnd, 1'b0}) report_mismatch("td_o bypass", dout[32:0], {rnd, 1'b0});
    end_test("1 idcode and bypass", err_start);

    err_start = errors;
    dtmcs_scan(32'h0, word);
    if (word !== expected_dtmcs(exp_status)) begin
      report_mismatch("dtmcs", word, expected_dtmcs(exp_status));
    end
    end_test("2 dtmcs fields", err_start);

    // Random writes, each followed by a read somewhere in the bank
    err_start = errors;
    jtag_ir_scan(dtm_pkg::IR_DMI);
    repeat (40) begin
      rnd  = $random(seed);
      addr = {3'b0, rnd[3:0]};
      rnd  = $random(seed);
      dmi_access(addr, rnd, dtm_pkg::DTM_WRITE);
      model[addr[3:0]] = rnd;
      rnd  = $random(seed);
      addr = {3'b0, rnd[3:0]};
      read_and_check(addr, model[addr[3:0]], exp_status);
    end
    end_test("3 random dmi accesses", err_start);

    err_start = errors;
    rnd  = $random(seed);
    addr = rnd[6:0] | 7'h10;                        // Unmapped
    exp_status = dtm_pkg::DMI_OP_FAILED;
    read_and_check(addr, 32'hDEAD_BEEF, exp_status);
    dtmcs_scan(32'h0, word);
    if (word !== expected_dtmcs(exp_status)) begin
      report_mismatch("dtmcs", word, expected_dtmcs(exp_status));
    end
    addr = {3'b0, rnd[3:0]};
    jtag_ir_scan(dtm_pkg::IR_DMI);
    dmi_access(addr, ~model[addr[3:0]], dtm_pkg::DTM_WRITE); // Dropped, status set
    dtmcs_scan(32'h0001_0000, word);                         // dmireset
    exp_status = dtm_pkg::DMI_NO_ERROR;
    jtag_ir_scan(dtm_pkg::IR_DMI);
    read_and_check(addr, model[addr[3:0]], exp_status);
    // Read update, then capture at once while the read is still pending
    jtag_dr_scan(41, {23'h0, addr, 32'h0, dtm_pkg::DTM_READ}, dout);
    jtag_dr_scan(41, 64'h0, dout);
    exp_status = dtm_pkg::DMI_BUSY;
    if (dout[1:0] !== exp_status) report_mismatch("dmi op", dout[1:0], exp_status);
    jtag_idle(SETTLE);
    dmi_access(addr, ~model[addr[3:0]], dtm_pkg::DTM_WRITE); // Dropped, busy
    dtmcs_scan(32'h0, word);
    if (word !== expected_dtmcs(exp_status)) begin
      report_mismatch("dtmcs", word, expected_dtmcs(exp_status));
    end
    end_test("4 dmi errors", err_start);

    err_start = errors;
    dtmcs_scan(32'h0001_0000, word);                // Captures busy, then clears it
    if (word !== expected_dtmcs(exp_status)) begin
      report_mismatch("dtmcs", word, expected_dtmcs(exp_status));
    end
    exp_status = dtm_pkg::DMI_NO_ERROR;
    dtmcs_scan(32'h0, word);
    if (word !== expected_dtmcs(exp_status)) begin
      report_mismatch("dtmcs", word, expected_dtmcs(exp_status));
    end
    jtag_ir_scan(dtm_pkg::IR_DMI);
    read_and_check(addr, model[addr[3:0]], exp_status);
    // dmihardreset empties the DMI register, bank stays
    rnd = $random(seed) | 32'h1;
    dmi_access(7'h05, rnd, dtm_pkg::DTM_WRITE);
    model[5] = rnd;
    dtmcs_scan(32'h0002_0000, word);
    jtag_ir_scan(dtm_pkg::IR_DMI);
    dmi_result(r_addr, r_data, r_op);
    if ({r_addr, r_data, r_op} !== 41'h0) begin
      report_mismatch("dmi dr after dmihardreset", {r_addr, r_data, r_op}, 41'h0);
    end
    read_and_check(7'h05, model[5], exp_status);
    // Same through Test-Logic-Reset
    rnd = $random(seed) | 32'h1;
    dmi_access(7'h0A, rnd, dtm_pkg::DTM_WRITE);
    model[10] = rnd;
    jtag_tap_reset();
    jtag_ir_scan(dtm_pkg::IR_DMI);
    dmi_result(r_addr, r_data, r_op);
    if ({r_addr, r_data, r_op} !== 41'h0) begin
      report_mismatch("dmi dr after tap reset", {r_addr, r_data, r_op}, 41'h0);
    end
    read_and_check(7'h0A, model[10], exp_status);
    end_test("5 status and dmi reset", err_start);

    $display("tests run: 5, passed: %0d, failed: %0d, check errors: %0d",
             5 - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
